//--- source/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// direct-mapped geometry, same for both caches
`define NUM_SETS 8

// 32-bit words in one cache line
`define WORDS_PER_LINE 8

// 64-bit beats in one line transfer to burst memory
`define BURSTS_PER_LINE 4

`endif

//--- source/mem_types_pkg.sv
`include "mem_settings.svh"

package mem_types_pkg;

    // one 256-bit line
    // caches see words, burst adaptor sees beats
    typedef union packed {
        logic [`WORDS_PER_LINE-1:0][31:0]  words;  // word select and byte merge
        logic [`BURSTS_PER_LINE-1:0][63:0] beats;  // burst order, beat 0 first
    } cacheline_u;

    // who holds the memory side of the arbiter
    typedef enum logic [1:0] {
        own_none   = 2'b00,
        own_icache = 2'b01,
        own_dcache = 2'b10
    } owner_e;

endpackage : mem_types_pkg

//--- source/line_if.sv
`timescale 1ns/100ps

interface line_if
    import mem_types_pkg::*;
();

    logic [31:0] addr;   // line aligned, low five bits zero
    logic        read;
    logic        write;
    cacheline_u  wdata;
    cacheline_u  rdata;  // valid only with resp
    logic        resp;   // one-cycle pulse

    // requester side
    modport cache (output addr, read, write, wdata, input rdata, resp);

    // responder side
    modport mem (input addr, read, write, wdata, output rdata, resp);

endinterface : line_if

//--- source/icache.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module icache
    import mem_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic [31:0] addr_i,
    input  logic        read_i,
    output logic [31:0] rdata_o,
    output logic        resp_o,
    output logic        hit_o,
    output logic        miss_o,
    line_if.cache       line_o
);

    localparam int IDX_W = $clog2(`NUM_SETS);
    localparam int OFF_W = $clog2(`WORDS_PER_LINE) + 2;
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CMP  = 2'd1;
    localparam logic [1:0] ST_FILL = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]          state_q;
    logic [`NUM_SETS-1:0] valid_q;
    logic [TAG_W-1:0]    tag_arr [`NUM_SETS];
    cacheline_u          data_arr [`NUM_SETS];
    logic [31:0]         addr_q;
    cacheline_u          line_q;  // line under access

    logic [IDX_W-1:0]    idx_q;
    logic [TAG_W-1:0]    tag_q;
    logic                hit;

    assign idx_q = addr_q[OFF_W +: IDX_W];
    assign tag_q = addr_q[31 -: TAG_W];
    assign hit   = valid_q[idx_q] && (tag_arr[idx_q] == tag_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (read_i) state_q <= ST_CMP;
                ST_CMP:  state_q <= hit ? ST_IDLE : ST_FILL;
                ST_FILL: begin
                    if (line_o.resp) begin
                        valid_q[idx_q] <= 1'b1;
                        state_q        <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;  // done, answer already given
            endcase
        end
    end

    // arrays and line register
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && read_i) begin
            addr_q <= addr_i;
            line_q <= data_arr[addr_i[OFF_W +: IDX_W]];
        end
        if (state_q == ST_FILL && line_o.resp) begin
            data_arr[idx_q] <= line_o.rdata;
            tag_arr[idx_q]  <= tag_q;
            line_q          <= line_o.rdata;
        end
    end

    assign resp_o  = (state_q == ST_CMP && hit) || (state_q == ST_DONE);
    assign hit_o   = (state_q == ST_CMP) && hit;
    assign miss_o  = (state_q == ST_CMP) && !hit;
    assign rdata_o = line_q.words[addr_q[OFF_W-1:2]];

    assign line_o.addr  = {tag_q, idx_q, {OFF_W{1'b0}}};
    assign line_o.read  = (state_q == ST_FILL);
    assign line_o.write = 1'b0;  // read-only
    assign line_o.wdata = '0;

endmodule : icache

//--- source/dcache.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module dcache
    import mem_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic [31:0] addr_i,
    input  logic        read_i,
    input  logic        write_i,
    input  logic [3:0]  wmask_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        resp_o,
    output logic        hit_o,
    output logic        miss_o,
    line_if.cache       line_o
);

    localparam int IDX_W = $clog2(`NUM_SETS);
    localparam int OFF_W = $clog2(`WORDS_PER_LINE) + 2;
    localparam int TAG_W = 32 - IDX_W - OFF_W;

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CMP  = 3'd1;
    localparam logic [2:0] ST_WB   = 3'd2;
    localparam logic [2:0] ST_FILL = 3'd3;
    localparam logic [2:0] ST_DONE = 3'd4;

    logic [2:0]           state_q;
    logic [`NUM_SETS-1:0] valid_q;
    logic [`NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]     tag_arr [`NUM_SETS];
    cacheline_u           data_arr [`NUM_SETS];
    logic [31:0]          addr_q;
    logic                 wr_q;    // access is a store
    cacheline_u           line_q;  // victim first, then the filled line

    logic [IDX_W-1:0]     idx_q;
    logic [TAG_W-1:0]     tag_q;
    logic [OFF_W-3:0]     word_q;
    logic                 hit;
    cacheline_u           merged;

    assign idx_q  = addr_q[OFF_W +: IDX_W];
    assign tag_q  = addr_q[31 -: TAG_W];
    assign word_q = addr_q[OFF_W-1:2];
    assign hit    = valid_q[idx_q] && (tag_arr[idx_q] == tag_q);

    // store bytes laid over the current line
    always_comb begin
        merged = line_q;
        for (int b = 0; b < 4; b++) begin
            if (wmask_i[b]) merged.words[word_q][8*b +: 8] = wdata_i[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (read_i || write_i) state_q <= ST_CMP;
                ST_CMP: begin
                    if (hit) begin
                        state_q <= ST_IDLE;
                        if (wr_q) dirty_q[idx_q] <= 1'b1;
                    end else if (valid_q[idx_q] && dirty_q[idx_q]) begin
                        state_q <= ST_WB;  // old line goes back first
                    end else begin
                        state_q <= ST_FILL;
                    end
                end
                ST_WB: if (line_o.resp) state_q <= ST_FILL;
                ST_FILL: begin
                    if (line_o.resp) begin
                        valid_q[idx_q] <= 1'b1;
                        dirty_q[idx_q] <= 1'b0;
                        state_q        <= ST_DONE;
                    end
                end
                default: begin
                    if (wr_q) dirty_q[idx_q] <= 1'b1;
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (read_i || write_i) begin
                    addr_q <= addr_i;
                    wr_q   <= write_i;
                    line_q <= data_arr[addr_i[OFF_W +: IDX_W]];
                end
            end
            ST_CMP:  if (hit && wr_q) data_arr[idx_q] <= merged;
            ST_FILL: begin
                if (line_o.resp) begin
                    data_arr[idx_q] <= line_o.rdata;
                    tag_arr[idx_q]  <= tag_q;
                    line_q          <= line_o.rdata;
                end
            end
            ST_DONE: if (wr_q) data_arr[idx_q] <= merged;  // write-allocate
            default: ;
        endcase
    end

    assign resp_o  = (state_q == ST_CMP && hit) || (state_q == ST_DONE);
    assign hit_o   = (state_q == ST_CMP) && hit;
    assign miss_o  = (state_q == ST_CMP) && !hit;
    assign rdata_o = line_q.words[word_q];

    // write-back goes to the victim's own address
    assign line_o.addr  = (state_q == ST_WB) ? {tag_arr[idx_q], idx_q, {OFF_W{1'b0}}}
                                             : {tag_q, idx_q, {OFF_W{1'b0}}};
    assign line_o.read  = (state_q == ST_FILL);
    assign line_o.write = (state_q == ST_WB);
    assign line_o.wdata = line_q;

endmodule : dcache

//--- source/line_arbiter.sv
`timescale 1ns/100ps

module line_arbiter
    import mem_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,
    line_if.mem   ic_i,
    line_if.mem   dc_i,
    line_if.cache mem_o
);

    owner_e owner_q;

    logic ic_req;
    logic dc_req;

    assign ic_req = ic_i.read || ic_i.write;
    assign dc_req = dc_i.read || dc_i.write;

    // grant taken from idle only, kept until the memory answers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            owner_q <= own_none;
        end else begin
            case (owner_q)
                own_none: begin
                    if (dc_req) begin
                        owner_q <= own_dcache;  // data side first
                    end else if (ic_req) begin
                        owner_q <= own_icache;
                    end
                end
                default: if (mem_o.resp) owner_q <= own_none;
            endcase
        end
    end

    // forward path, owner's request only
    always_comb begin
        mem_o.addr  = '0;
        mem_o.read  = 1'b0;
        mem_o.write = 1'b0;
        mem_o.wdata = '0;
        case (owner_q)
            own_icache: begin
                mem_o.addr  = ic_i.addr;
                mem_o.read  = ic_i.read;
                mem_o.write = ic_i.write;
                mem_o.wdata = ic_i.wdata;
            end
            own_dcache: begin
                mem_o.addr  = dc_i.addr;
                mem_o.read  = dc_i.read;
                mem_o.write = dc_i.write;
                mem_o.wdata = dc_i.wdata;
            end
            default: ;
        endcase
    end

    // return path, no added cycle
    always_comb begin
        ic_i.rdata = '0;
        dc_i.rdata = '0;
        ic_i.resp  = 1'b0;
        dc_i.resp  = 1'b0;
        if (owner_q == own_icache) begin
            ic_i.rdata = mem_o.rdata;
            ic_i.resp  = mem_o.resp;
        end
        if (owner_q == own_dcache) begin
            dc_i.rdata = mem_o.rdata;
            dc_i.resp  = mem_o.resp;
        end
    end

endmodule : line_arbiter

//--- source/burst_adaptor.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module burst_adaptor
    import mem_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    line_if.mem         line_i,
    output logic [31:0] bmem_address_o,
    output logic        bmem_read_o,
    output logic        bmem_write_o,
    output logic [63:0] bmem_wdata_o,
    input  logic [63:0] bmem_rdata_i,
    input  logic        bmem_resp_i
);

    localparam int CNT_W = $clog2(`BURSTS_PER_LINE);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RD   = 2'd1;
    localparam logic [1:0] ST_WR   = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]       state_q;
    logic [CNT_W-1:0] cnt_q;   // beat number
    logic [31:0]      addr_q;
    cacheline_u       buf_q;   // gathered or outgoing line

    logic             last_beat;

    assign last_beat = bmem_resp_i && (cnt_q == CNT_W'(`BURSTS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (line_i.read) begin
                        state_q <= ST_RD;
                    end else if (line_i.write) begin
                        state_q <= ST_WR;
                    end
                end
                ST_RD, ST_WR: begin
                    if (bmem_resp_i) cnt_q <= cnt_q + 1'b1;
                    if (last_beat) state_q <= ST_DONE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (line_i.read || line_i.write)) begin
            addr_q <= line_i.addr;
            buf_q  <= line_i.wdata;  // only meaningful for a write
        end
        if (state_q == ST_RD && bmem_resp_i) buf_q.beats[cnt_q] <= bmem_rdata_i;
    end

    assign bmem_address_o = addr_q;
    assign bmem_read_o    = (state_q == ST_RD);
    assign bmem_write_o   = (state_q == ST_WR);
    assign bmem_wdata_o   = buf_q.beats[cnt_q];

    assign line_i.rdata = buf_q;
    assign line_i.resp  = (state_q == ST_DONE);  // one cycle after beat four

endmodule : burst_adaptor

//--- source/mem_hier.sv
`timescale 1ns/100ps

module mem_hier (
    input  logic        clk,
    input  logic        rst_i,

    // fetch port
    input  logic [31:0] imem_addr_i,
    input  logic        imem_read_i,
    output logic [31:0] imem_rdata_o,
    output logic        imem_resp_o,

    // load/store port
    input  logic [31:0] dmem_addr_i,
    input  logic        dmem_read_i,
    input  logic        dmem_write_i,
    input  logic [3:0]  dmem_wmask_i,
    input  logic [31:0] dmem_wdata_i,
    output logic [31:0] dmem_rdata_o,
    output logic        dmem_resp_o,

    // burst memory
    output logic [31:0] bmem_address_o,
    output logic        bmem_read_o,
    output logic        bmem_write_o,
    output logic [63:0] bmem_wdata_o,
    input  logic [63:0] bmem_rdata_i,
    input  logic        bmem_resp_i,

    // event pulses
    output logic        i_hit_o,
    output logic        i_miss_o,
    output logic        d_hit_o,
    output logic        d_miss_o
);

    line_if ic_line ();
    line_if dc_line ();
    line_if mem_line ();

    icache i_icache (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (imem_addr_i),
        .read_i  (imem_read_i),
        .rdata_o (imem_rdata_o),
        .resp_o  (imem_resp_o),
        .hit_o   (i_hit_o),
        .miss_o  (i_miss_o),
        .line_o  (ic_line.cache)
    );

    dcache i_dcache (
        .clk     (clk),
        .rst_i   (rst_i),
        .addr_i  (dmem_addr_i),
        .read_i  (dmem_read_i),
        .write_i (dmem_write_i),
        .wmask_i (dmem_wmask_i),
        .wdata_i (dmem_wdata_i),
        .rdata_o (dmem_rdata_o),
        .resp_o  (dmem_resp_o),
        .hit_o   (d_hit_o),
        .miss_o  (d_miss_o),
        .line_o  (dc_line.cache)
    );

    line_arbiter i_arbiter (
        .clk   (clk),
        .rst_i (rst_i),
        .ic_i  (ic_line.mem),
        .dc_i  (dc_line.mem),
        .mem_o (mem_line.cache)
    );

    burst_adaptor i_adaptor (
        .clk            (clk),
        .rst_i          (rst_i),
        .line_i         (mem_line.mem),
        .bmem_address_o (bmem_address_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_write_o   (bmem_write_o),
        .bmem_wdata_o   (bmem_wdata_o),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_resp_i    (bmem_resp_i)
    );

endmodule : mem_hier

//--- tb/mem_hier_assert.sv
`timescale 1ns/100ps

module mem_hier_assert
    import mem_types_pkg::*;
(
    input logic   clk,
    input logic   rst_i,
    input logic   bmem_read,
    input logic   bmem_write,
    input logic   line_read,
    input logic   line_write,
    input logic   line_resp,
    input owner_e owner
);

    // one burst direction at a time
    one_direction: assert property (@(posedge clk) disable iff (rst_i)
        !(bmem_read && bmem_write))
        else $error("bmem read and write are high together");

    resp_with_request: assert property (@(posedge clk) disable iff (rst_i)
        line_resp |-> (line_read || line_write))
        else $error("line resp without a held read or write");

    // grant only moves from idle or at the end of a transfer
    grant_held: assert property (@(posedge clk) disable iff (rst_i)
        (owner != $past(owner)) |-> (($past(owner) == own_none) || $past(line_resp)))
        else $error("arbiter owner changed in the middle of a transfer");

endmodule : mem_hier_assert

bind mem_hier mem_hier_assert i_assert (
    .clk        (clk),
    .rst_i      (rst_i),
    .bmem_read  (bmem_read_o),
    .bmem_write (bmem_write_o),
    .line_read  (mem_line.read),
    .line_write (mem_line.write),
    .line_resp  (mem_line.resp),
    .owner      (i_arbiter.owner_q)
);

//--- tb/tb_mem_hier.sv
`timescale 1ns/100ps
`include "mem_settings.svh"

module tb_mem_hier;

    localparam int MEM_WORDS  = 512;
    localparam int TIMEOUT    = 200;  // cycles per wait
    localparam int LINE_BYTES = 4 * `WORDS_PER_LINE;

    localparam logic [1:0] P_I = 2'd0;
    localparam logic [1:0] P_D = 2'd1;
    localparam logic [1:0] P_B = 2'd2;  // fetch and load together
    localparam logic [1:0] OP_RD  = 2'd0;
    localparam logic [1:0] OP_WR  = 2'd1;
    localparam logic [1:0] OP_CHK = 2'd2;  // burst memory word vs shadow

    typedef struct packed {
        logic [1:0]  port;
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        exp_hit;
    } entry_t;

    logic        clk;
    logic        rst_i;
    logic [31:0] imem_addr_i;
    logic        imem_read_i;
    logic [31:0] imem_rdata_o;
    logic        imem_resp_o;
    logic [31:0] dmem_addr_i;
    logic        dmem_read_i;
    logic        dmem_write_i;
    logic [3:0]  dmem_wmask_i;
    logic [31:0] dmem_wdata_i;
    logic [31:0] dmem_rdata_o;
    logic        dmem_resp_o;
    logic [31:0] bmem_address_o;
    logic        bmem_read_o;
    logic        bmem_write_o;
    logic [63:0] bmem_wdata_o;
    logic [63:0] bmem_rdata_i;
    logic        bmem_resp_i;
    logic        i_hit_o;
    logic        i_miss_o;
    logic        d_hit_o;
    logic        d_miss_o;

    entry_t      stim [$];
    logic [31:0] bmem [MEM_WORDS];    // burst memory contents
    logic [31:0] shadow [MEM_WORDS];  // what the CPU should see
    logic [31:0] itag [`NUM_SETS];
    logic [31:0] dtag [`NUM_SETS];
    logic [`NUM_SETS-1:0] ivalid = '0;
    logic [`NUM_SETS-1:0] dvalid = '0;
    logic [`NUM_SETS-1:0] ddirty = '0;

    int errors = 0;
    int timeouts = 0;
    int n_ihit = 0;
    int n_imiss = 0;
    int n_dhit = 0;
    int n_dmiss = 0;
    int n_wb = 0;
    int p_ihit = 0;
    int p_imiss = 0;
    int p_dhit = 0;
    int p_dmiss = 0;
    int p_wb = 0;

    mem_hier i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wd, input logic [3:0] m);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) r[8*b +: 8] = wd[8*b +: 8];
        end
        return r;
    endfunction

    task automatic init_memories();
        logic [31:0] lfsr;
        logic [31:0] w;
        lfsr = 32'd18;
        for (int i = 0; i < MEM_WORDS; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);  // one step per bit
                w[b] = lfsr[0];
            end
            bmem[i]   = w;
            shadow[i] = w;
        end
    endtask

    // two cycles to the first beat, then one beat per cycle
    initial begin : burst_memory
        int base;
        bmem_resp_i  = 1'b0;
        bmem_rdata_i = '0;
        forever begin
            @(posedge clk);
            #2;
            if (!rst_i && (bmem_read_o || bmem_write_o)) begin
                base = int'(bmem_address_o[10:2]);
                if (bmem_write_o) n_wb++;
                repeat (2) @(posedge clk);
                #2;
                for (int b = 0; b < `BURSTS_PER_LINE; b++) begin
                    bmem_resp_i = 1'b1;
                    if (bmem_read_o) bmem_rdata_i = {bmem[base+2*b+1], bmem[base+2*b]};
                    @(negedge clk);
                    if (bmem_write_o) begin
                        bmem[base+2*b]   = bmem_wdata_o[31:0];
                        bmem[base+2*b+1] = bmem_wdata_o[63:32];
                    end
                    @(posedge clk);
                    #2;
                end
                bmem_resp_i = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_i) begin
            if (i_hit_o) n_ihit++;
            if (i_miss_o) n_imiss++;
            if (d_hit_o) n_dhit++;
            if (d_miss_o) n_dmiss++;
        end
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input logic [1:0] port, input logic [1:0] op,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wmask, input logic exp_hit);
        stim.push_back(entry_t'{port, op, addr, wdata, wmask, exp_hit});
    endtask

    // direct-mapped tag model, also counts write-backs of dirty victims
    task automatic update_model(input logic [1:0] port, input logic [31:0] addr,
                                input logic wr);
        int          idx;
        logic [31:0] tag;
        idx = int'((addr / LINE_BYTES) % `NUM_SETS);
        tag = addr / (LINE_BYTES * `NUM_SETS);
        if (port == P_I) begin
            if (ivalid[idx] && itag[idx] == tag) p_ihit++;
            else p_imiss++;
            ivalid[idx] = 1'b1;
            itag[idx]   = tag;
        end else if (dvalid[idx] && dtag[idx] == tag) begin
            p_dhit++;
            if (wr) ddirty[idx] = 1'b1;
        end else begin
            p_dmiss++;
            if (dvalid[idx] && ddirty[idx]) p_wb++;
            dvalid[idx] = 1'b1;
            dtag[idx]   = tag;
            ddirty[idx] = wr;
        end
    endtask

    // holds the request until resp_o, then drops it one edge later
    task automatic do_access(input logic [1:0] port, input entry_t e,
                             output logic [31:0] rdata, output logic hit, output time t_done);
        int   cyc;
        logic done;
        cyc   = 0;
        done  = 1'b0;
        hit   = 1'b0;
        rdata = 'x;
        if (port == P_I) begin
            imem_addr_i = e.addr;
            imem_read_i = 1'b1;
        end else begin
            dmem_addr_i  = e.addr;
            dmem_read_i  = (e.op == OP_RD);
            dmem_write_i = (e.op == OP_WR);
            dmem_wmask_i = e.wmask;
            dmem_wdata_i = e.wdata;
        end
        while (!done && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            if (port == P_I) begin
                hit   = hit | i_hit_o;
                done  = imem_resp_o;
                rdata = imem_rdata_o;
            end else begin
                hit   = hit | d_hit_o;
                done  = dmem_resp_o;
                rdata = dmem_rdata_o;
            end
        end
        t_done = $time;
        @(posedge clk);
        #2;
        if (port == P_I) imem_read_i = 1'b0;
        else begin
            dmem_read_i  = 1'b0;
            dmem_write_i = 1'b0;
        end
        if (!done) begin
            timeouts++;
            $display("timeout: the %s port got no response within %0d cycles",
                     (port == P_I) ? "fetch" : "load/store", TIMEOUT);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] got_i;
        logic [31:0] got_d;
        logic        hit_i;
        logic        hit_d;
        time         t_i;
        time         t_d;
        int          w;
        w = int'(e.addr[10:2]);
        if (e.op == OP_CHK) begin
            compare_value($sformatf("burst memory word %h", e.addr), bmem[w], shadow[w]);
        end else if (e.port == P_B) begin
            fork
                do_access(P_I, e, got_i, hit_i, t_i);
                do_access(P_D, e, got_d, hit_d, t_d);
            join
            update_model(P_I, e.addr, 1'b0);
            update_model(P_D, e.addr, 1'b0);
            compare_value($sformatf("fetch data %h", e.addr), got_i, shadow[w]);
            compare_value($sformatf("load data %h", e.addr), got_d, shadow[w]);
            compare_value($sformatf("fetch hit %h", e.addr), hit_i, e.exp_hit);
            compare_value($sformatf("load hit %h", e.addr), hit_d, e.exp_hit);
            compare_value("load done before fetch", t_d < t_i, 1);  // dcache wins
        end else begin
            do_access(e.port, e, got_d, hit_d, t_d);
            update_model(e.port, e.addr, e.op == OP_WR);
            compare_value($sformatf("hit at %h", e.addr), hit_d, e.exp_hit);
            if (e.op == OP_WR) shadow[w] = merge_bytes(shadow[w], e.wdata, e.wmask);
            else compare_value($sformatf("read data %h", e.addr), got_d, shadow[w]);
        end
    endtask

    task automatic check_idle(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            compare_value("idle outputs", {imem_resp_o, dmem_resp_o, i_hit_o, i_miss_o,
                          d_hit_o, d_miss_o, bmem_read_o, bmem_write_o}, 0);
        end
    endtask

    initial begin : main
        rst_i        = 1'b1;
        imem_addr_i  = '0;
        imem_read_i  = 1'b0;
        dmem_addr_i  = '0;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        dmem_wmask_i = '0;
        dmem_wdata_i = '0;
        init_memories();
        add_entry(P_I, OP_RD,  32'h0000_0000, 32'h0, 4'h0, 1'b0);  // cold fetch
        add_entry(P_I, OP_RD,  32'h0000_0004, 32'h0, 4'h0, 1'b1);
        add_entry(P_I, OP_RD,  32'h0000_001C, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_WR,  32'h0000_0080, 32'hA5A5_1234, 4'b0011, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0080, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_WR,  32'h0000_0080, 32'h00EE_0000, 4'b0100, 1'b1);
        add_entry(P_D, OP_RD,  32'h0000_0080, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_WR,  32'h0000_0044, 32'hDEAD_BEEF, 4'b1111, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0144, 32'h0, 4'h0, 1'b0);  // dirty victim out
        add_entry(P_D, OP_CHK, 32'h0000_0044, 32'h0, 4'h0, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0044, 32'h0, 4'h0, 1'b0);
        add_entry(P_B, OP_RD,  32'h0000_0300, 32'h0, 4'h0, 1'b0);  // both miss at once
        add_entry(P_I, OP_RD,  32'h0000_0304, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_RD,  32'h0000_0308, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_WR,  32'h0000_0208, 32'h7700_0000, 4'b1000, 1'b0);
        add_entry(P_I, OP_RD,  32'h0000_0100, 32'h0, 4'h0, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0208, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_RD,  32'h0000_0088, 32'h0, 4'h0, 1'b1);
        add_entry(P_D, OP_WR,  32'h0000_0488, 32'h1357_9BDF, 4'b1111, 1'b0);
        add_entry(P_D, OP_CHK, 32'h0000_0080, 32'h0, 4'h0, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0080, 32'h0, 4'h0, 1'b0);
        add_entry(P_D, OP_CHK, 32'h0000_0488, 32'h0, 4'h0, 1'b0);
        add_entry(P_D, OP_RD,  32'h0000_0084, 32'h0, 4'h0, 1'b1);
        repeat (16) @(posedge clk);
        #2;
        rst_i = 1'b0;
        check_idle(3);
        @(posedge clk);
        #2;
        foreach (stim[i]) begin
            if (timeouts == 0) run_entry(stim[i]);
        end
        compare_value("i_hit_o pulses", n_ihit, p_ihit);
        compare_value("i_miss_o pulses", n_imiss, p_imiss);
        compare_value("d_hit_o pulses", n_dhit, p_dhit);
        compare_value("d_miss_o pulses", n_dmiss, p_dmiss);
        compare_value("write-back bursts", n_wb, p_wb);
        $display("done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_mem_hier

//--- all.f
+incdir+source
source/mem_types_pkg.sv
source/line_if.sv
source/icache.sv
source/dcache.sv
source/line_arbiter.sv
source/burst_adaptor.sv
source/mem_hier.sv
tb/mem_hier_assert.sv
tb/tb_mem_hier.sv

//--- Makefile
TOP := tb_mem_hier

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard source/*) $(wildcard tb/*)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
